// File: include/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

`define DATA_WIDTH   16
`define REG_COUNT    8
`define REG_SEL_W    3
`define MUL_STEPS    16

// Opcodes, bits [15:11] of the instruction.
`define OP_NOP       5'b00000
`define OP_HALT      5'b00001
`define OP_ADDI      5'b01000
`define OP_SLLI      5'b10100
`define OP_ALU       5'b11011
`define OP_MUL       5'b11100

// R-format funct field, bits [1:0].
`define FN_ADD       2'b00
`define FN_SUB       2'b01
`define FN_XOR       2'b10
`define FN_AND       2'b11

`endif

// File: hw/corePkg.sv
`include "core_config.svh"

package corePkg;

	// **************************************************
	// Instruction word views
	// **************************************************
	typedef struct packed {
		logic [4:0]            opcode;
		logic [`REG_SEL_W-1:0] rs;
		logic [`REG_SEL_W-1:0] rt;
		logic [`REG_SEL_W-1:0] rd;
		logic [1:0]            funct;
	} rType_t;

	typedef struct packed {
		logic [4:0]            opcode;
		logic [`REG_SEL_W-1:0] rs;
		logic [`REG_SEL_W-1:0] rd;
		logic [4:0]            imm;
	} iType_t;

	typedef union packed {
		rType_t rType;
		iType_t iType;
	} instrWord_t;

	// **************************************************
	// Control and pipeline bundles
	// **************************************************
	typedef enum logic [2:0] {
		aluAdd  = 3'd0,
		aluSub  = 3'd1,
		aluAnd  = 3'd2,
		aluXor  = 3'd3,
		aluSll  = 3'd4,
		aluPass = 3'd5
	} aluOp_t;

	typedef struct packed {
		aluOp_t aluOp;
		logic   aluSrcImm;    // Operand B is the immediate.
		logic   isMul;
		logic   regWrite;
		logic   halt;
	} ctrlWord_t;

	typedef struct packed {
		ctrlWord_t              ctrl;
		logic [`DATA_WIDTH-1:0] pcAdd2;
		logic [`DATA_WIDTH-1:0] readData1;
		logic [`DATA_WIDTH-1:0] readData2;
		logic [`DATA_WIDTH-1:0] immExt;
		logic [`REG_SEL_W-1:0]  rs;
		logic [`REG_SEL_W-1:0]  rt;
		logic [`REG_SEL_W-1:0]  writeReg;
		logic                   err;
		logic                   valid;
	} idExBundle_t;

	typedef enum logic [1:0] {
		mulIdle   = 2'd0,
		mulRun    = 2'd1,
		mulFinish = 2'd2
	} mulState_t;

endpackage

// File: hw/instrDecoder.sv
`timescale 1ns/1ps
`include "core_config.svh"

module instrDecoder (
	input  corePkg::instrWord_t     instr,
	input  logic [`DATA_WIDTH-1:0]  pcAdd2,
	input  logic                    instrValid,
	input  logic [`DATA_WIDTH-1:0]  readData1,
	input  logic [`DATA_WIDTH-1:0]  readData2,
	output logic [`REG_SEL_W-1:0]   readReg1,
	output logic [`REG_SEL_W-1:0]   readReg2,
	output corePkg::idExBundle_t    decoded
);

	import corePkg::*;

	logic [4:0] opcode;
	logic       isRType;
	ctrlWord_t  ctrl;
	logic       illegal;

	assign opcode = instr.rType.opcode;    // Same position in both views.

	// rs and rt sit at the same bits in both formats.
	assign readReg1 = instr.rType.rs;
	assign readReg2 = instr.rType.rt;

	// **************************************************
	// Control word
	// **************************************************
	always_comb begin
		ctrl = '0;
		ctrl.aluOp = aluPass;
		isRType = 1'b0;
		illegal = 1'b0;
		case (opcode)
			`OP_NOP: begin
			end
			`OP_HALT: ctrl.halt = 1'b1;
			`OP_ALU: begin
				isRType = 1'b1;
				ctrl.regWrite = 1'b1;
				case (instr.rType.funct)
					`FN_ADD: ctrl.aluOp = aluAdd;
					`FN_SUB: ctrl.aluOp = aluSub;
					`FN_AND: ctrl.aluOp = aluAnd;
					`FN_XOR: ctrl.aluOp = aluXor;
					default: ctrl.aluOp = aluAdd;
				endcase
			end
			`OP_ADDI: begin
				ctrl.aluOp = aluAdd;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			`OP_SLLI: begin
				ctrl.aluOp = aluSll;
				ctrl.aluSrcImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			`OP_MUL: begin
				isRType = 1'b1;
				ctrl.isMul = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			default: illegal = 1'b1;    // Control word stays inert.
		endcase
	end

	always_comb begin
		decoded.ctrl = ctrl;
		decoded.pcAdd2 = pcAdd2;
		decoded.readData1 = readData1;
		decoded.readData2 = readData2;
		decoded.immExt = {{(`DATA_WIDTH-5){instr.iType.imm[4]}}, instr.iType.imm};
		decoded.rs = instr.rType.rs;
		decoded.rt = isRType ? instr.rType.rt : '0;
		decoded.writeReg = isRType ? instr.rType.rd : instr.iType.rd;
		decoded.err = illegal;
		decoded.valid = instrValid;
	end

endmodule

// File: hw/regFile.sv
`timescale 1ns/1ps
`include "core_config.svh"

module regFile (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`REG_SEL_W-1:0]  readReg1,
	input  logic [`REG_SEL_W-1:0]  readReg2,
	input  logic                   wbEn,
	input  logic [`REG_SEL_W-1:0]  wbReg,
	input  logic [`DATA_WIDTH-1:0] wbData,
	output logic [`DATA_WIDTH-1:0] readData1,
	output logic [`DATA_WIDTH-1:0] readData2
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wbEn) begin
			regs[wbReg] <= wbData;
		end
	end

	// Write-through so decode sees the value retiring this cycle.
	assign readData1 = (wbEn && (wbReg == readReg1)) ? wbData : regs[readReg1];
	assign readData2 = (wbEn && (wbReg == readReg2)) ? wbData : regs[readReg2];

endmodule

// File: hw/idExReg.sv
`timescale 1ns/1ps
`include "core_config.svh"

module idExReg (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 stall,
	input  corePkg::idExBundle_t decoded,
	output corePkg::idExBundle_t idEx
);

	import corePkg::*;

	idExBundle_t entry;

	// An error only counts for a real instruction, and it kills the write.
	always_comb begin
		entry = decoded;
		entry.err = decoded.err & decoded.valid;
		entry.ctrl.regWrite = decoded.ctrl.regWrite & decoded.valid & ~decoded.err;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			idEx.valid <= 1'b0;
			idEx.ctrl.regWrite <= 1'b0;
		end else if (!stall) begin
			idEx <= entry;    // Hold everything while stalled.
		end
	end

endmodule

// File: hw/executeUnit.sv
`timescale 1ns/1ps
`include "core_config.svh"

module executeUnit (
	input  logic                   clk,
	input  logic                   reset,
	input  corePkg::idExBundle_t   idEx,
	input  logic                   mulStart,
	input  logic                   mulStep,
	input  logic                   stall,
	output logic                   exValid,
	output logic [`DATA_WIDTH-1:0] exResult,
	output logic                   exErr,
	output logic                   halted,
	output logic                   wbEn,
	output logic [`REG_SEL_W-1:0]  wbReg,
	output logic [`DATA_WIDTH-1:0] wbData
);

	import corePkg::*;

	localparam int shiftWidth = $clog2(`DATA_WIDTH);

	logic [`DATA_WIDTH-1:0] opA;
	logic [`DATA_WIDTH-1:0] opB;
	logic [`DATA_WIDTH-1:0] aluOut;
	logic [`DATA_WIDTH-1:0] result;
	logic [`DATA_WIDTH-1:0] mulCand;
	logic [`DATA_WIDTH-1:0] mulPlier;
	logic [`DATA_WIDTH-1:0] mulAcc;
	logic                   fire;

	assign opA = idEx.readData1;
	assign opB = idEx.ctrl.aluSrcImm ? idEx.immExt : idEx.readData2;

	always_comb begin
		case (idEx.ctrl.aluOp)
			aluAdd:  aluOut = opA + opB;
			aluSub:  aluOut = opA - opB;
			aluAnd:  aluOut = opA & opB;
			aluXor:  aluOut = opA ^ opB;
			aluSll:  aluOut = opA << opB[shiftWidth-1:0];
			default: aluOut = idEx.pcAdd2;    // Pass reports PC+2.
		endcase
	end

	// **************************************************
	// Shift-and-add multiply, one bit per step
	// **************************************************
	always_ff @(posedge clk) begin
		if (mulStart) begin
			mulCand <= idEx.readData1;
			mulPlier <= idEx.readData2;
			mulAcc <= '0;
		end else if (mulStep) begin
			if (mulPlier[0]) begin
				mulAcc <= mulAcc + mulCand;
			end
			mulCand <= mulCand << 1;
			mulPlier <= mulPlier >> 1;
		end
	end

	assign result = idEx.ctrl.isMul ? mulAcc : aluOut;

	// A multiply retires only in its last, unstalled cycle.
	assign fire = idEx.valid & ~halted & ~(idEx.ctrl.isMul & stall);

	assign wbEn = fire & idEx.ctrl.regWrite;
	assign wbReg = idEx.writeReg;
	assign wbData = result;

	always_ff @(posedge clk) begin
		if (reset) begin
			exValid <= 1'b0;
			exErr <= 1'b0;
			halted <= 1'b0;
		end else begin
			exValid <= fire;
			exErr <= fire & idEx.err;
			halted <= halted | (fire & idEx.ctrl.halt);    // Sticky.
		end
	end

	always_ff @(posedge clk) begin
		exResult <= result;
	end

endmodule

// File: hw/mulStallFsm.sv
`timescale 1ns/1ps
`include "core_config.svh"

module mulStallFsm (
	input  logic                 clk,
	input  logic                 reset,
	input  corePkg::idExBundle_t idEx,
	input  logic                 timerDone,
	output logic                 stall,
	output logic                 mulStart,
	output logic                 mulStep,
	output logic                 timerLoad,
	output logic                 ready
);

	import corePkg::*;

	mulState_t state;
	mulState_t nextState;
	logic      haltHold;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mulIdle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		mulStart = 1'b0;
		mulStep = 1'b0;
		case (state)
			mulIdle: begin
				if (idEx.valid && idEx.ctrl.isMul) begin
					mulStart = 1'b1;
					nextState = mulRun;
				end
			end
			mulRun: begin
				mulStep = 1'b1;
				if (timerDone) begin
					nextState = mulFinish;
				end
			end
			// Product is final, multiply leaves EX this cycle.
			mulFinish: nextState = mulIdle;
			default: nextState = mulIdle;
		endcase
	end

	// A halt sits in ID/EX until reset and keeps the front end frozen.
	assign haltHold = idEx.valid & idEx.ctrl.halt;

	assign stall = mulStart | (state == mulRun) | haltHold;
	assign timerLoad = mulStart;
	assign ready = ~stall;

endmodule

// File: hw/mulStepTimer.sv
`timescale 1ns/1ps
`include "core_config.svh"

module mulStepTimer (
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  logic enable,
	output logic done
);

	localparam int countWidth = $clog2(`MUL_STEPS);

	logic [countWidth-1:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (load) begin
			count <= countWidth'(`MUL_STEPS - 1);    // Last step sees zero.
		end else if (enable && (count != '0)) begin
			count <= count - 1'b1;
		end
	end

	assign done = enable & (count == '0);

endmodule

// File: hw/decodeExecuteTop.sv
`timescale 1ns/1ps
`include "core_config.svh"

module decodeExecuteTop (
	input  logic                   clk,
	input  logic                   reset,
	input  corePkg::instrWord_t    instr,
	input  logic [`DATA_WIDTH-1:0] pcAdd2,
	input  logic                   instrValid,
	output logic                   ready,
	output logic                   exValid,
	output logic [`DATA_WIDTH-1:0] exResult,
	output logic                   exErr,
	output logic                   halted
);

	import corePkg::*;

	idExBundle_t            decoded;
	idExBundle_t            idEx;
	logic [`REG_SEL_W-1:0]  readReg1;
	logic [`REG_SEL_W-1:0]  readReg2;
	logic [`DATA_WIDTH-1:0] readData1;
	logic [`DATA_WIDTH-1:0] readData2;
	logic                   stall;
	logic                   mulStart;
	logic                   mulStep;
	logic                   timerLoad;
	logic                   timerDone;
	logic                   wbEn;
	logic [`REG_SEL_W-1:0]  wbReg;
	logic [`DATA_WIDTH-1:0] wbData;

	// **************************************************
	// Decode stage
	// **************************************************
	instrDecoder instrDecoder_inst (
		.instr(instr), .pcAdd2(pcAdd2), .instrValid(instrValid),
		.readData1(readData1), .readData2(readData2),
		.readReg1(readReg1), .readReg2(readReg2), .decoded(decoded)
	);

	regFile regFile_inst (
		.clk(clk), .reset(reset), .readReg1(readReg1), .readReg2(readReg2),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
		.readData1(readData1), .readData2(readData2)
	);

	idExReg idExReg_inst (
		.clk(clk), .reset(reset), .stall(stall), .decoded(decoded), .idEx(idEx)
	);

	// **************************************************
	// Execute stage and multiply control
	// **************************************************
	executeUnit executeUnit_inst (
		.clk(clk), .reset(reset), .idEx(idEx),
		.mulStart(mulStart), .mulStep(mulStep), .stall(stall),
		.exValid(exValid), .exResult(exResult), .exErr(exErr), .halted(halted),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
	);

	mulStallFsm mulStallFsm_inst (
		.clk(clk), .reset(reset), .idEx(idEx), .timerDone(timerDone),
		.stall(stall), .mulStart(mulStart), .mulStep(mulStep),
		.timerLoad(timerLoad), .ready(ready)
	);

	mulStepTimer mulStepTimer_inst (
		.clk(clk), .reset(reset), .load(timerLoad), .enable(mulStep), .done(timerDone)
	);

endmodule

// File: sim/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic reset
);

	localparam real halfPeriod = 2.0;    // 4 ns clock.
	localparam int resetCycles = 16;

	initial begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		#1;
		reset = 1'b0;    // Released with the stimulus, 1 ns after the edge.
	end

endmodule

// File: sim/decodeExecuteTb.sv
`timescale 1ns/1ps
`include "core_config.svh"

module decodeExecuteTb;

	import corePkg::*;

	localparam int clkPeriodNs = 4;
	localparam int instrBudget = 130;
	localparam int watchdogCycles = instrBudget * (`MUL_STEPS + 4) + 2 * 16 + 200;

	typedef struct packed {
		logic [`DATA_WIDTH-1:0] result;
		logic                   err;
		logic                   checkRes;    // Only ALU, immediate and multiply results.
		logic                   isHalt;
		int                     cycle;       // Cycle in which exValid is due.
	} expEntry_t;

	logic                   clk;
	logic                   rstClk;
	logic                   rstTb;
	logic                   rstAll;
	instrWord_t             instr;
	logic [`DATA_WIDTH-1:0] pcAdd2;
	logic                   instrValid;
	logic                   ready;
	logic                   exValid;
	logic [`DATA_WIDTH-1:0] exResult;
	logic                   exErr;
	logic                   halted;

	logic [`DATA_WIDTH-1:0] model [`REG_COUNT];
	expEntry_t              expQ [$];
	expEntry_t              popEntry;
	logic [`DATA_WIDTH-1:0] pcNext;
	logic [`DATA_WIDTH-1:0] popResult;
	logic                   popNow;
	logic                   popHas;
	logic                   popCheck;
	logic                   popErr;
	logic                   expHalted;
	logic                   afterReset;
	logic                   runDone;
	int                     popCycle;
	int                     cycleNow;
	int                     lowRun;
	int                     runLen;
	int                     errorCount;
	int                     resultCount;

	assign rstAll = rstClk | rstTb;

	tbClock tbClock_inst (.clk(clk), .reset(rstClk));

	decodeExecuteTop decodeExecuteTop_inst (
		.clk(clk), .reset(rstAll), .instr(instr), .pcAdd2(pcAdd2), .instrValid(instrValid),
		.ready(ready), .exValid(exValid), .exResult(exResult), .exErr(exErr), .halted(halted)
	);

	// **************************************************
	// Instruction builders
	// **************************************************
	function automatic instrWord_t rWord(input logic [4:0] op, input logic [2:0] rs,
		input logic [2:0] rt, input logic [2:0] rd, input logic [1:0] fn);
		instrWord_t w;
		w.rType.opcode = op;
		w.rType.rs = rs;
		w.rType.rt = rt;
		w.rType.rd = rd;
		w.rType.funct = fn;
		return w;
	endfunction

	function automatic instrWord_t iWord(input logic [4:0] op, input logic [2:0] rs,
		input logic [2:0] rd, input logic [4:0] imm);
		instrWord_t w;
		w.iType.opcode = op;
		w.iType.rs = rs;
		w.iType.rd = rd;
		w.iType.imm = imm;
		return w;
	endfunction

	function automatic logic [2:0] rndReg();
		return 3'($urandom_range(7, 0));
	endfunction

	// Offers one instruction, waits for it to be taken and queues what it must produce.
	task automatic issue(input instrWord_t word);
		logic                   acc;
		logic [`DATA_WIDTH-1:0] a;
		logic [`DATA_WIDTH-1:0] b;
		logic [`DATA_WIDTH-1:0] imm;
		expEntry_t              e;
		int                     lat;
		instr = word;
		pcAdd2 = pcNext;
		instrValid = 1'b1;
		acc = 1'b0;
		while (!acc) begin
			@(negedge clk);
			acc = ready;
			@(posedge clk);
		end
		#1;
		a = model[word.rType.rs];
		b = model[word.rType.rt];
		imm = `DATA_WIDTH'(word.iType.imm);
		if (word.iType.imm[4]) begin
			imm = imm - `DATA_WIDTH'(32);    // Negative immediate.
		end
		e = '0;
		e.checkRes = 1'b1;
		lat = 1;
		case (word.rType.opcode)
			`OP_ALU: begin
				case (word.rType.funct)
					`FN_ADD: e.result = a + b;
					`FN_SUB: e.result = a - b;
					`FN_AND: e.result = a & b;
					default: e.result = a ^ b;
				endcase
				model[word.rType.rd] = e.result;
			end
			`OP_ADDI: begin
				e.result = a + imm;
				model[word.iType.rd] = e.result;
			end
			`OP_SLLI: begin
				e.result = a << word.iType.imm[3:0];
				model[word.iType.rd] = e.result;
			end
			`OP_MUL: begin
				e.result = a * b;    // Low half of the product.
				model[word.rType.rd] = e.result;
				lat = `MUL_STEPS + 2;
			end
			`OP_HALT: begin
				e.checkRes = 1'b0;
				e.isHalt = 1'b1;
			end
			`OP_NOP: e.checkRes = 1'b0;
			default: begin
				e.checkRes = 1'b0;
				e.err = 1'b1;    // Destination must keep its value.
			end
		endcase
		e.cycle = cycleNow + lat;
		expQ.push_back(e);
		pcNext = pcNext + 16'd2;
		instrValid = 1'b0;
	endtask

	task automatic drain();
		while (expQ.size() != 0) @(posedge clk);
		#1;
	endtask

	task automatic applyReset();
		rstTb = 1'b1;
		repeat (16) @(posedge clk);
		#1;
		rstTb = 1'b0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			model[i] = '0;
		end
		expQ.delete();
		expHalted = 1'b0;
		afterReset = 1'b1;
		@(posedge clk);
		#1;
		afterReset = 1'b0;
	endtask

	// **************************************************
	// Monitor updated 1 ns after each edge
	// **************************************************
	initial begin
		cycleNow = 0;
		lowRun = 0;
		forever begin
			@(posedge clk);
			cycleNow++;
			#1;
			popNow = 1'b0;
			runDone = 1'b0;
			if (rstAll) begin
				lowRun = 0;
			end else begin
				if (exValid) begin
					popNow = 1'b1;
					popHas = (expQ.size() != 0);
					if (popHas) begin
						popEntry = expQ.pop_front();
						popResult = popEntry.result;
						popCheck = popEntry.checkRes;
						popErr = popEntry.err;
						popCycle = popEntry.cycle;
						resultCount++;
						if (popEntry.isHalt) begin
							expHalted = 1'b1;
						end
					end
				end
				if (!ready) begin
					lowRun++;
				end else if (lowRun != 0) begin
					runLen = lowRun;    // Length of the stall that just ended.
					runDone = 1'b1;
					lowRun = 0;
				end
			end
		end
	end

	// **************************************************
	// Checks at the falling edge
	// **************************************************
	strayValid: assert property (@(negedge clk) disable iff (rstAll) popNow |-> popHas)
		else begin
			errorCount++;
			$display("exValid rose at %0t with no instruction outstanding", $time);
		end

	resultMatch: assert property (@(negedge clk) disable iff (rstAll)
		(popNow && popHas && popCheck) |-> (exResult == popResult))
		else begin
			errorCount++;
			$display("ERROR %0t exResult expected %h actual %h", $time, popResult, exResult);
		end

	errMatch: assert property (@(negedge clk) disable iff (rstAll)
		(popNow && popHas) |-> (exErr == popErr))
		else begin
			errorCount++;
			$display("ERROR %0t exErr expected %b actual %b", $time, popErr, exErr);
		end

	latencyMatch: assert property (@(negedge clk) disable iff (rstAll)
		(popNow && popHas) |-> (cycleNow == popCycle))
		else begin
			errorCount++;
			$display("ERROR %0t exValid cycle expected %0d actual %0d", $time, popCycle, cycleNow);
		end

	haltedMatch: assert property (@(negedge clk) disable iff (rstAll) halted == expHalted)
		else begin
			errorCount++;
			$display("ERROR %0t halted expected %b actual %b", $time, expHalted, halted);
		end

	haltFreeze: assert property (@(negedge clk) disable iff (rstAll) expHalted |-> !ready)
		else begin
			errorCount++;
			$display("ready went high at %0t although the core is halted", $time);
		end

	stallLength: assert property (@(negedge clk) disable iff (rstAll)
		runDone |-> (runLen == `MUL_STEPS + 1))
		else begin
			errorCount++;
			$display("ERROR %0t ready low cycles expected %0d actual %0d", $time,
				`MUL_STEPS + 1, runLen);
		end

	resetState: assert property (@(negedge clk) disable iff (rstAll)
		afterReset |-> (ready && !exValid && !exErr && !halted))
		else begin
			errorCount++;
			$display("Outputs at %0t are not in their reset state after reset", $time);
		end

	initial begin
		#(watchdogCycles * clkPeriodNs);
		$display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
		$display("Test failed");
		$finish;
	end

	// **************************************************
	// Stimulus
	// **************************************************
	initial begin
		logic [2:0] rd;
		void'($urandom(32'h955a));
		instr = '0;
		pcAdd2 = '0;
		instrValid = 1'b0;
		rstTb = 1'b0;
		pcNext = 16'h0002;
		errorCount = 0;
		resultCount = 0;
		popNow = 1'b0;
		popHas = 1'b0;
		popCheck = 1'b0;
		popErr = 1'b0;
		popResult = '0;
		popCycle = 0;
		runLen = 0;
		runDone = 1'b0;
		expHalted = 1'b0;
		afterReset = 1'b0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			model[i] = '0;
		end
		@(negedge rstClk);
		afterReset = 1'b1;
		@(posedge clk);
		#1;
		afterReset = 1'b0;

		// Registers start at zero, so ADDI from r0 loads a signed immediate.
		for (int i = 1; i < `REG_COUNT; i++) begin
			issue(iWord(`OP_ADDI, 3'd0, 3'(i), 5'($urandom_range(31, 0))));
		end
		issue(iWord(`OP_ADDI, 3'd2, 3'd1, 5'b11101));    // r1 = r2 - 3.
		issue(rWord(`OP_ALU, 3'd1, 3'd2, 3'd3, `FN_ADD));
		issue(rWord(`OP_ALU, 3'd3, 3'd1, 3'd4, `FN_SUB));
		issue(rWord(`OP_ALU, 3'd4, 3'd3, 3'd3, `FN_XOR));
		for (int i = 0; i < 40; i++) begin
			issue(rWord(`OP_ALU, rndReg(), rndReg(), rndReg(), 2'($urandom_range(3, 0))));
		end
		for (int i = 0; i < 6; i++) begin
			issue(iWord(`OP_SLLI, rndReg(), rndReg(), 5'($urandom_range(15, 0))));
		end
		for (int i = 0; i < 4; i++) begin
			rd = rndReg();
			issue(rWord(`OP_MUL, rndReg(), rndReg(), rd, 2'b00));
			issue(rWord(`OP_ALU, rd, rndReg(), rndReg(), `FN_ADD));    // Held through the stall.
		end
		issue(rWord(`OP_NOP, 3'd0, 3'd0, 3'd0, 2'b00));
		issue(rWord(`OP_NOP, 3'd0, 3'd0, 3'd0, 2'b00));
		issue(iWord(5'b11111, 3'd1, 3'd5, 5'd9));
		issue(rWord(`OP_ALU, 3'd5, 3'd0, 3'd6, `FN_ADD));
		for (int i = 0; i < 30; i++) begin
			case ($urandom_range(3, 0))
				0: issue(rWord(`OP_ALU, rndReg(), rndReg(), rndReg(), 2'($urandom_range(3, 0))));
				1: issue(iWord(`OP_ADDI, rndReg(), rndReg(), 5'($urandom_range(31, 0))));
				2: issue(iWord(`OP_SLLI, rndReg(), rndReg(), 5'($urandom_range(15, 0))));
				default: issue(rWord(`OP_MUL, rndReg(), rndReg(), rndReg(), 2'b00));
			endcase
		end

		// Halt, then offer one more instruction that must never be taken.
		issue(iWord(`OP_HALT, 3'd0, 3'd0, 5'd0));
		drain();
		instr = rWord(`OP_ALU, 3'd1, 3'd2, 3'd7, `FN_ADD);
		instrValid = 1'b1;
		repeat (10) @(posedge clk);
		#1;
		instrValid = 1'b0;
		applyReset();
		issue(iWord(`OP_ADDI, 3'd0, 3'd2, 5'b10000));
		issue(rWord(`OP_ALU, 3'd2, 3'd2, 3'd3, `FN_ADD));
		issue(rWord(`OP_ALU, 3'd3, 3'd2, 3'd4, `FN_AND));
		drain();

		$display("Summary: %0d results checked, %0d errors", resultCount, errorCount);
		if (errorCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: list.f
+incdir+include
hw/corePkg.sv
hw/instrDecoder.sv
hw/regFile.sv
hw/idExReg.sv
hw/executeUnit.sv
hw/mulStallFsm.sv
hw/mulStepTimer.sv
hw/decodeExecuteTop.sv
sim/tbClock.sv
sim/decodeExecuteTb.sv

// File: Makefile
# Verilator build for the decode/execute slice.

VERILATOR ?= verilator
TOP       ?= decodeExecuteTb
RTL_TOP   ?= decodeExecuteTop
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
